// ==== build.f ====
common/core_pkg.sv
common/slot_ctrl_if.sv
logic/instr_intake.sv
pipeline/pipe_slot.sv
pipeline/bubble_ctrl.sv
pipeline/exec_unit.sv
logic/writeback_unit.sv
logic/scalar_core.sv
tb/tb_clock.sv
tb/tb_core.sv

// ==== Makefile ====
TB_TOP = tb_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module scalar_core
	verilator --lint-only --timing -f build.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing -j 0 -f build.f --top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP)

clean:
	rm -rf obj_dir

// ==== tb/tb_core.sv ====
// Testbench top for the scalar core, runs programs against an ISA model and checks every result
`timescale 1ns/1ps
`default_nettype none

module tb_core;
    import core_pkg::*;

    localparam int clk_period_ns = 40;
    localparam int cycles_per_instr = 30;
    localparam int margin_ns = 2000;

    typedef struct packed {
        opcode_e op;
        logic [reg_idx_width-1:0] rd;
        logic [reg_idx_width-1:0] rs1;
        logic [reg_idx_width-1:0] rs2;
        logic [imm_width-1:0] imm;
        logic [7:0] gap;
    } instr_t;

    logic clk;
    logic reset;
    logic instr_req;
    opcode_e instr_op;
    logic [reg_idx_width-1:0] instr_rd;
    logic [reg_idx_width-1:0] instr_rs1;
    logic [reg_idx_width-1:0] instr_rs2;
    logic [imm_width-1:0] instr_imm;
    logic instr_ack;
    logic [reg_idx_width-1:0] res_reg;
    logic [data_width-1:0] res_data;
    logic res_req;
    logic res_ack;

    instr_t prog [$];
    logic [reg_idx_width-1:0] exp_reg [$];
    logic [data_width-1:0] exp_data [$];
    bit prog_built;
    bit slow_ack;
    int bp_start;

    tb_clock clock_gen (.clk, .reset);

    scalar_core dut0 (
        .clk, .reset, .instr_req, .instr_op, .instr_rd, .instr_rs1, .instr_rs2,
        .instr_imm, .instr_ack, .res_reg, .res_data, .res_req, .res_ack
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("Fail %s got 0x%0h expected 0x%0h", name, got, expected));
        end
    endtask

    // Sequential ISA model, fills the expected result queues
    function automatic void ref_run();
        logic [data_width-1:0] regs [num_regs];
        logic [data_width-1:0] value;
        int drop;
        for (int r = 0; r < num_regs; r++) begin
            regs[r] = '0;
        end
        drop = 0;
        foreach (prog[i]) begin
            if (drop > 0) begin
                // Discarded by an earlier taken skip
                drop--;
            end else begin
                value = '0;
                case (prog[i].op)
                    op_li: value = {{(data_width - imm_width){1'b0}}, prog[i].imm};
                    op_add: value = regs[prog[i].rs1] + regs[prog[i].rs2];
                    op_sub: value = regs[prog[i].rs1] - regs[prog[i].rs2];
                    op_xor: value = regs[prog[i].rs1] ^ regs[prog[i].rs2];
                    op_skz: if (regs[prog[i].rs1] == '0) drop = skip_len;
                    default: value = '0;
                endcase
                if (prog[i].op inside {op_li, op_add, op_sub, op_xor}) begin
                    regs[prog[i].rd] = value;
                    exp_reg.push_back(prog[i].rd);
                    exp_data.push_back(value);
                end
            end
        end
    endfunction

    function automatic void push_instr(opcode_e op, int rd, int rs1, int rs2, int imm, int gap);
        instr_t ins;
        ins.op = op;
        ins.rd = reg_idx_width'(rd);
        ins.rs1 = reg_idx_width'(rs1);
        ins.rs2 = reg_idx_width'(rs2);
        ins.imm = imm_width'(imm);
        ins.gap = 8'(gap);
        prog.push_back(ins);
    endfunction

    function automatic int rand_in(int lo, int hi);
        return int'($urandom_range(hi, lo));
    endfunction

    function automatic void build_arith(int count, int max_gap);
        opcode_e op;
        for (int n = 0; n < count; n++) begin
            case (rand_in(0, 4))
                0: op = op_li;
                1: op = op_add;
                2: op = op_sub;
                3: op = op_xor;
                default: op = op_nop;
            endcase
            push_instr(op, rand_in(0, 7), rand_in(0, 7), rand_in(0, 7), rand_in(0, 255),
                       rand_in(0, max_gap));
        end
    endfunction

    // Every instruction reads the rd of the one just before it
    function automatic void build_chain(int count);
        int prev;
        int rd;
        prev = rand_in(0, 7);
        push_instr(op_li, prev, 0, 0, rand_in(0, 255), 0);
        for (int n = 0; n < count; n++) begin
            rd = rand_in(0, 7);
            push_instr(opcode_e'(rand_in(2, 4)), rd, prev,
                       (rand_in(0, 1) == 1) ? prev : rand_in(0, 7), 0, 0);
            prev = rd;
        end
    endfunction

    // Doubling 0xff past 16 bits, then a negative difference
    function automatic void build_wrap();
        push_instr(op_li, 2, 0, 0, 8'hff, 0);
        for (int n = 0; n < 9; n++) begin
            push_instr(op_add, 2, 2, 2, 0, 0);
        end
        push_instr(op_li, 4, 0, 0, 1, 0);
        push_instr(op_sub, 3, 4, 2, 0, 0);
        push_instr(op_add, 5, 2, 2, 0, 0);
    endfunction

    function automatic void build_skip(int gap_lo, int gap_hi);
        // Taken, two victims, then a survivor
        push_instr(op_li, 5, 0, 0, 0, rand_in(gap_lo, gap_hi));
        push_instr(op_skz, 0, 5, 0, 0, rand_in(gap_lo, gap_hi));
        push_instr(op_li, 6, 0, 0, rand_in(1, 255), rand_in(gap_lo, gap_hi));
        push_instr(op_add, 7, 6, 6, 0, rand_in(gap_lo, gap_hi));
        push_instr(op_xor, 4, 5, 7, 0, rand_in(gap_lo, gap_hi));
        // Not taken, nothing dropped
        push_instr(op_li, 3, 0, 0, rand_in(1, 255), rand_in(gap_lo, gap_hi));
        push_instr(op_skz, 0, 3, 0, 0, rand_in(gap_lo, gap_hi));
        push_instr(op_sub, 2, 3, 3, 0, rand_in(gap_lo, gap_hi));
        push_instr(op_add, 1, 3, 0, 0, rand_in(gap_lo, gap_hi));
        // A taken skip whose first victim is itself a skip
        push_instr(op_li, 5, 0, 0, 0, rand_in(gap_lo, gap_hi));
        push_instr(op_skz, 0, 5, 0, 0, rand_in(gap_lo, gap_hi));
        push_instr(op_skz, 0, 5, 0, 0, rand_in(gap_lo, gap_hi));
        push_instr(op_li, 6, 0, 0, rand_in(0, 255), rand_in(gap_lo, gap_hi));
        push_instr(op_li, 7, 0, 0, rand_in(0, 255), rand_in(gap_lo, gap_hi));
    endfunction

    // Four-phase transfer of one instruction
    task automatic send_instr(input instr_t ins);
        repeat (ins.gap) @(posedge clk);
        instr_op <= ins.op;
        instr_rd <= ins.rd;
        instr_rs1 <= ins.rs1;
        instr_rs2 <= ins.rs2;
        instr_imm <= ins.imm;
        instr_req <= 1'b1;
        do begin
            @(posedge clk);
        end while (!instr_ack);
        instr_req <= 1'b0;
        do begin
            @(posedge clk);
        end while (instr_ack);
    endtask

    initial begin : stimulus
        int drain;
        instr_req <= 1'b0;
        instr_op <= op_nop;
        instr_rd <= '0;
        instr_rs1 <= '0;
        instr_rs2 <= '0;
        instr_imm <= '0;
        void'($urandom(32'hd41c_fd59));

        // r1 = r0 + r0 shows the register file starts at zero
        push_instr(op_add, 1, 0, 0, 0, 0);
        build_arith(40, 3);
        build_wrap();
        build_chain(20);
        build_skip(0, 0);
        build_skip(8, 12);
        build_skip(0, 3);
        bp_start = prog.size();
        build_arith(40, 0);
        build_chain(10);
        ref_run();
        prog_built = 1'b1;

        @(posedge clk);
        while (reset) begin
            @(posedge clk);
        end
        check_value("instr_ack", 32'(instr_ack), 32'h0);
        check_value("res_req", 32'(res_req), 32'h0);

        foreach (prog[i]) begin
            // Back-pressure section gets slow result acks
            if (i == bp_start) slow_ack <= 1'b1;
            send_instr(prog[i]);
        end

        drain = 0;
        while (exp_reg.size() != 0 && drain < 400) begin
            @(posedge clk);
            drain++;
        end
        // Room for any surplus result to show up
        repeat (20) @(posedge clk);
        if (exp_reg.size() != 0) begin
            fail_run($sformatf("%0d expected results never arrived", exp_reg.size()));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

    initial begin : result_responder
        int delay;
        res_ack <= 1'b0;
        forever begin
            @(posedge clk);
            if (res_req) begin
                delay = slow_ack ? rand_in(4, 6) : rand_in(0, 6);
                repeat (delay) @(posedge clk);
                res_ack <= 1'b1;
                do begin
                    @(posedge clk);
                end while (res_req);
                res_ack <= 1'b0;
            end
        end
    end

    // One expected entry per rising res_req
    initial begin : compare_results
        logic req_prev;
        logic [reg_idx_width-1:0] want_reg;
        logic [data_width-1:0] want_data;
        req_prev = 1'b0;
        forever begin
            @(posedge clk);
            if (res_req && !req_prev) begin
                if (exp_reg.size() == 0) begin
                    fail_run("a result arrived when none was expected");
                end else begin
                    want_reg = exp_reg.pop_front();
                    want_data = exp_data.pop_front();
                    check_value("res_reg", 32'(res_reg), 32'(want_reg));
                    check_value("res_data", 32'(res_data), 32'(want_data));
                end
            end
            req_prev = res_req;
        end
    end

    initial begin : watchdog
        longint limit_ns;
        wait (prog_built);
        limit_ns = longint'(prog.size()) * cycles_per_instr * clk_period_ns + margin_ns;
        #(limit_ns);
        fail_run($sformatf("run timed out after %0d ns", limit_ns));
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
// Clock and reset source for the core testbench, instantiated once by the testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);
    // 40 ns period
    localparam int half_period_ns = 20;
    localparam int reset_cycles = 3;

    initial begin
        clk = 1'b0;
        forever begin
            #(half_period_ns) clk = ~clk;
        end
    end

    // Reset drops on a rising edge, same as the rest of the stimulus
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== logic/scalar_core.sv ====
// Top level of the pipelined scalar core with four-phase instruction and result ports
`timescale 1ns/1ps
`default_nettype none

module scalar_core (
    input logic clk,
    input logic reset,
    input logic instr_req,
    input core_pkg::opcode_e instr_op,
    input logic [core_pkg::reg_idx_width-1:0] instr_rd,
    input logic [core_pkg::reg_idx_width-1:0] instr_rs1,
    input logic [core_pkg::reg_idx_width-1:0] instr_rs2,
    input logic [core_pkg::imm_width-1:0] instr_imm,
    output logic instr_ack,
    output logic [core_pkg::reg_idx_width-1:0] res_reg,
    output logic [core_pkg::data_width-1:0] res_data,
    output logic res_req,
    input logic res_ack
);
    import core_pkg::*;

    slot_payload_t buf_payload;
    slot_payload_t read_payload;
    slot_payload_t alu_payload;
    slot_payload_t slot_in [num_slots];
    slot_payload_t slot_out [num_slots];
    logic [num_slots-1:0] slot_valid;
    logic [num_slots-1:0] slot_prev_valid;
    logic buf_valid, buf_stall, buf_flush, drop_load;
    logic [drop_cnt_width-1:0] drop_count;
    logic [data_width-1:0] rd_data_a, rd_data_b;
    logic branch_taken, wb_ready, wb_retire;

    slot_ctrl_if slot_ctrl [num_slots] ();

    instr_intake u_intake (
        .clk, .reset, .instr_req, .instr_op, .instr_rd, .instr_rs1, .instr_rs2,
        .instr_imm, .instr_ack, .buf_stall, .buf_flush, .drop_load, .drop_count,
        .buf_valid, .buf_payload
    );

    // Payload chain: buffer, decode, register read, execute, ALU, writeback
    assign slot_in[slot_dec] = buf_payload;
    assign slot_in[slot_exe] = read_payload;
    assign slot_in[slot_wb] = alu_payload;

    for (genvar i = 0; i < num_slots; i++) begin : g_slot
        pipe_slot u_slot (
            .clk, .reset, .ctrl(slot_ctrl[i]),
            .prev_valid(slot_prev_valid[i]), .prev_payload(slot_in[i]),
            .valid(slot_valid[i]), .payload(slot_out[i])
        );
        // Only the writeback slot can be held by the outside world
        assign slot_ctrl[i].ready = (i == slot_wb) ? wb_ready : 1'b1;
        // Held or flushed predecessor hands over a bubble
        if (i == 0) begin : g_head
            assign slot_prev_valid[i] = buf_valid & ~buf_stall & ~buf_flush;
        end else begin : g_body
            assign slot_prev_valid[i] = slot_valid[i-1] & ~slot_ctrl[i-1].stall
                                        & ~slot_ctrl[i-1].flush;
        end
    end

    bubble_ctrl u_bubble (
        .slots(slot_ctrl), .dec_payload(slot_out[slot_dec]), .buf_valid,
        .branch_taken, .buf_stall, .buf_flush, .drop_load, .drop_count
    );

    // Operands read out of the register file as decode moves to execute
    always_comb begin
        read_payload = slot_out[slot_dec];
        read_payload.opa = rd_data_a;
        read_payload.opb = rd_data_b;
    end

    exec_unit u_exec (
        .exe_valid(slot_valid[slot_exe]), .exe_payload(slot_out[slot_exe]),
        .wb_payload_in(alu_payload), .branch_taken
    );

    assign wb_retire = slot_valid[slot_wb] & ~slot_ctrl[slot_wb].stall;

    writeback_unit u_wb (
        .clk, .reset,
        .rd_idx_a(slot_out[slot_dec].rs1), .rd_idx_b(slot_out[slot_dec].rs2),
        .rd_data_a, .rd_data_b,
        .wb_valid(slot_valid[slot_wb]), .wb_payload(slot_out[slot_wb]),
        .wb_retire, .wb_ready, .res_reg, .res_data, .res_req, .res_ack
    );

endmodule

`default_nettype wire

// ==== logic/writeback_unit.sv ====
// Register file, writeback retirement and four-phase result sender
`timescale 1ns/1ps
`default_nettype none

module writeback_unit (
    input logic clk,
    input logic reset,
    input logic [core_pkg::reg_idx_width-1:0] rd_idx_a,
    input logic [core_pkg::reg_idx_width-1:0] rd_idx_b,
    output logic [core_pkg::data_width-1:0] rd_data_a,
    output logic [core_pkg::data_width-1:0] rd_data_b,
    input logic wb_valid,
    input core_pkg::slot_payload_t wb_payload,
    input logic wb_retire,
    output logic wb_ready,
    output logic [core_pkg::reg_idx_width-1:0] res_reg,
    output logic [core_pkg::data_width-1:0] res_data,
    output logic res_req,
    input logic res_ack
);
    import core_pkg::*;

    logic [data_width-1:0] regs [num_regs];
    hs_state_e state;
    logic retire_wr;

    // Decode-side operand reads
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

    // Skip and nop retire silently
    assign retire_wr = wb_valid && wb_retire && writes_reg(wb_payload.op);

    // Writeback slot stays held until the sender is back to idle
    assign wb_ready = (state == hs_idle);
    assign res_req = (state == hs_active);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (retire_wr) begin
            regs[wb_payload.rd] <= wb_payload.result;
        end
    end

    always_ff @(posedge clk) begin
        if (retire_wr) begin
            res_reg <= wb_payload.rd;
            res_data <= wb_payload.result;
        end
    end

    // Result handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= hs_idle;
        end else begin
            case (state)
                // Start sending on the retire edge
                hs_idle: if (retire_wr) state <= hs_active;
                // req falls once ack seen
                hs_active: if (res_ack) state <= hs_release;
                // Wait for ack to drop before taking the next result
                hs_release: if (!res_ack) state <= hs_idle;
                default: state <= hs_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== pipeline/exec_unit.sv ====
// Combinational ALU and skip decision between the execute and writeback slots
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input logic exe_valid,
    input core_pkg::slot_payload_t exe_payload,
    output core_pkg::slot_payload_t wb_payload_in,
    output logic branch_taken
);
    import core_pkg::*;

    always_comb begin
        wb_payload_in = exe_payload;
        case (exe_payload.op)
            // Immediate is zero-extended
            op_li: wb_payload_in.result = data_width'(exe_payload.imm);
            // Add and subtract wrap at 16 bits
            op_add: wb_payload_in.result = exe_payload.opa + exe_payload.opb;
            op_sub: wb_payload_in.result = exe_payload.opa - exe_payload.opb;
            op_xor: wb_payload_in.result = exe_payload.opa ^ exe_payload.opb;
            // Nop and skip produce no value
            default: wb_payload_in.result = '0;
        endcase
    end

    // Skip if rs1 is zero
    assign branch_taken = exe_valid && (exe_payload.op == op_skz) && (exe_payload.opa == '0);

endmodule

`default_nettype wire

// ==== pipeline/bubble_ctrl.sv ====
// Turns slot readiness, decode hazards and a taken skip into stall and flush controls
`timescale 1ns/1ps
`default_nettype none

module bubble_ctrl (
    slot_ctrl_if.ctrl slots [core_pkg::num_slots],
    input core_pkg::slot_payload_t dec_payload,
    input logic buf_valid,
    input logic branch_taken,
    output logic buf_stall,
    output logic buf_flush,
    output logic drop_load,
    output logic [core_pkg::drop_cnt_width-1:0] drop_count
);
    import core_pkg::*;

    logic [num_slots-1:0] ready_v;
    logic [num_slots-1:0] valid_v;
    logic [num_slots-1:0] wr_v;
    logic [reg_idx_width-1:0] rd_v [num_slots];
    logic [num_slots-1:0] direct_stall;
    logic [num_slots-1:0] bp_stall;
    logic [num_slots-1:0] flush_v;
    logic hazard;
    logic taken;

    // Unpack the interface array into plain vectors
    for (genvar i = 0; i < num_slots; i++) begin : g_slot
        assign ready_v[i] = slots[i].ready;
        assign valid_v[i] = slots[i].valid;
        assign wr_v[i] = slots[i].rd_wr;
        assign rd_v[i] = slots[i].rd;
        // Never stall and flush together
        assign slots[i].flush = flush_v[i];
        assign slots[i].stall = bp_stall[i] & ~flush_v[i];
    end

    // No forwarding, so any pending write to a decode source holds decode
    always_comb begin
        hazard = 1'b0;
        for (int s = slot_exe; s < num_slots; s++) begin
            if (valid_v[s] && wr_v[s]) begin
                if (reads_rs1(dec_payload.op) && rd_v[s] == dec_payload.rs1) hazard = 1'b1;
                if (reads_rs2(dec_payload.op) && rd_v[s] == dec_payload.rs2) hazard = 1'b1;
            end
        end
        hazard = hazard & valid_v[slot_dec];
    end

    always_comb begin
        direct_stall = ~ready_v;
        direct_stall[slot_dec] = direct_stall[slot_dec] | hazard;
        // Backpressure, a stall holds every older stage too
        bp_stall[num_slots-1] = direct_stall[num_slots-1];
        for (int i = num_slots - 2; i >= 0; i--) begin
            bp_stall[i] = bp_stall[i+1] | direct_stall[i];
        end
    end

    // Skip only counts on the edge it leaves execute, or a held skip would fire twice
    assign taken = branch_taken & ~bp_stall[slot_exe];

    always_comb begin
        flush_v = '0;
        flush_v[slot_dec] = taken;
    end

    // Intake buffer sits in front of decode
    assign buf_flush = taken;
    assign buf_stall = bp_stall[slot_dec] & ~taken;

    // Whatever the flush did not catch is dropped at the intake
    assign drop_load = taken;
    assign drop_count = drop_cnt_width'(skip_len - int'(valid_v[slot_dec]) - int'(buf_valid));

endmodule

`default_nettype wire

// ==== pipeline/pipe_slot.sv ====
// One pipeline register stage that holds, advances, bubbles or flushes its payload
`timescale 1ns/1ps
`default_nettype none

module pipe_slot (
    input logic clk,
    input logic reset,
    slot_ctrl_if.slot ctrl,
    input logic prev_valid,
    input core_pkg::slot_payload_t prev_payload,
    output logic valid,
    output core_pkg::slot_payload_t payload
);
    import core_pkg::*;

    // Status for hazard checks in the controller
    assign ctrl.valid = valid;
    assign ctrl.rd = payload.rd;
    assign ctrl.rd_wr = writes_reg(payload.op);

    // Flush beats stall
    // prev_valid arrives already masked when the predecessor is held or flushed
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (ctrl.flush) begin
            valid <= 1'b0;
        end else if (!ctrl.stall) begin
            valid <= prev_valid;
        end
    end

    // Payload follows the slot, a bubble just carries stale data
    always_ff @(posedge clk) begin
        if (!ctrl.stall) begin
            payload <= prev_payload;
        end
    end

endmodule

`default_nettype wire

// ==== logic/instr_intake.sv ====
// Four-phase instruction receiver with a one-entry buffer feeding the decode slot
`timescale 1ns/1ps
`default_nettype none

module instr_intake (
    input logic clk,
    input logic reset,
    input logic instr_req,
    input core_pkg::opcode_e instr_op,
    input logic [core_pkg::reg_idx_width-1:0] instr_rd,
    input logic [core_pkg::reg_idx_width-1:0] instr_rs1,
    input logic [core_pkg::reg_idx_width-1:0] instr_rs2,
    input logic [core_pkg::imm_width-1:0] instr_imm,
    output logic instr_ack,
    input logic buf_stall,
    input logic buf_flush,
    input logic drop_load,
    input logic [core_pkg::drop_cnt_width-1:0] drop_count,
    output logic buf_valid,
    output core_pkg::slot_payload_t buf_payload
);
    import core_pkg::*;

    hs_state_e state;
    logic [drop_cnt_width-1:0] drop_cnt;
    logic [drop_cnt_width-1:0] drop_eff;
    logic space;
    logic capture;

    // A fresh skip count from the controller takes effect on this same edge
    assign drop_eff = drop_load ? drop_count : drop_cnt;

    // Buffer is free, or its entry moves into decode on this edge
    assign space = !buf_valid || !buf_stall;
    assign capture = (state == hs_idle) && instr_req && space;

    assign instr_ack = (state == hs_active);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= hs_idle;
        end else begin
            case (state)
                hs_idle: if (capture) state <= hs_active;
                // Hold ack until the source drops req
                hs_active: if (!instr_req) state <= hs_idle;
                default: state <= hs_idle;
            endcase
        end
    end

    // Skip drop counter, one decrement per discarded arrival
    always_ff @(posedge clk) begin
        if (reset) begin
            drop_cnt <= '0;
        end else if (capture && drop_eff != '0) begin
            drop_cnt <= drop_eff - 1'b1;
        end else begin
            drop_cnt <= drop_eff;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_valid <= 1'b0;
        end else if (capture) begin
            // Instructions behind a taken skip are acked and thrown away
            buf_valid <= (drop_eff == '0);
        end else if (buf_flush || !buf_stall) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            buf_payload <= '0;
            buf_payload.op <= instr_op;
            buf_payload.rd <= instr_rd;
            buf_payload.rs1 <= instr_rs1;
            buf_payload.rs2 <= instr_rs2;
            buf_payload.imm <= instr_imm;
        end
    end

endmodule

`default_nettype wire

// ==== common/slot_ctrl_if.sv ====
// Per-slot control bundle between a pipeline slot and the bubble controller
`timescale 1ns/1ps
`default_nettype none

interface slot_ctrl_if;
    import core_pkg::*;

    // Slot status, seen by the controller
    logic valid;
    logic [reg_idx_width-1:0] rd;
    logic rd_wr;
    // Driven at the top level, low only when the result port is busy
    logic ready;

    // Controller decisions for this slot
    logic stall;
    logic flush;

    modport slot (
        output valid,
        output rd,
        output rd_wr,
        input stall,
        input flush
    );

    modport ctrl (
        input valid,
        input rd,
        input rd_wr,
        input ready,
        output stall,
        output flush
    );

endinterface

`default_nettype wire

// ==== common/core_pkg.sv ====
// Shared core constants, opcode and handshake enums, and slot payload type for RTL and testbench
`default_nettype none

package core_pkg;

    // Pipeline shape
    localparam int num_slots = 3;
    localparam int slot_dec = 0;
    localparam int slot_exe = 1;
    localparam int slot_wb = 2;

    // Register file and datapath
    localparam int num_regs = 8;
    localparam int reg_idx_width = 3;
    localparam int data_width = 16;
    localparam int imm_width = 8;

    // Taken skip discards this many younger instructions
    localparam int skip_len = 2;
    localparam int drop_cnt_width = 2;

    typedef enum logic [2:0] {
        op_nop,
        op_li,
        op_add,
        op_sub,
        op_xor,
        op_skz
    } opcode_e;

    // Four-phase handshake phases
    typedef enum logic [1:0] {
        hs_idle,
        hs_active,
        hs_release
    } hs_state_e;

    // 68 bits, operands filled in at register read, result at execute
    typedef struct packed {
        opcode_e op;
        logic [reg_idx_width-1:0] rd;
        logic [reg_idx_width-1:0] rs1;
        logic [reg_idx_width-1:0] rs2;
        logic [imm_width-1:0] imm;
        logic [data_width-1:0] opa;
        logic [data_width-1:0] opb;
        logic [data_width-1:0] result;
    } slot_payload_t;

    function automatic logic writes_reg(opcode_e op);
        return op inside {op_li, op_add, op_sub, op_xor};
    endfunction

    function automatic logic reads_rs1(opcode_e op);
        return op inside {op_add, op_sub, op_xor, op_skz};
    endfunction

    function automatic logic reads_rs2(opcode_e op);
        return op inside {op_add, op_sub, op_xor};
    endfunction

endpackage

`default_nettype wire
